// ==== compile.f ====
verilog/vlsu_pkg.sv
verilog/vlsu_control.sv
verilog/vlsu_address_gen.sv
verilog/vlsu_store_lanes.sv
verilog/vlsu_load_assembler.sv
verilog/vector_lsu.sv
tests/vlsu_checker.sv
tests/tb_vector_lsu.sv

// ==== tests/tb_vector_lsu.sv ====
// Testbench top with clock, reset, one-cycle memory, random commands and watchdog

module tb_vector_lsu
    import vlsu_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_CMDS        = 200;
    localparam int CMD_CYCLES      = 16;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CMDS * CMD_CYCLES;

    logic             clk;
    logic             reset_n;
    logic             start_i;
    logic             is_store_i;
    addr_mode_e       mode_i;
    eew_e             eew_i;
    vl_t              vl_i;
    logic             vm_i;
    logic [VLENB-1:0] mask_i;
    word_t            base_address_i;
    word_t            stride_i;
    vreg_t            write_data_i;
    word_t            mem_read_data_i;
    logic             busy_o;
    logic             done_o;
    word_t            mem_address_o;
    logic             mem_read_enable_o;
    byte_en_t         mem_write_enable_o;
    word_t            mem_write_data_o;
    vreg_t            read_data_o;
    int               mismatch_count;
    int               error_count;
    int               checked_count;
    logic [7:0]       mem [256];

    vector_lsu dut_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .start_i            (start_i),
        .is_store_i         (is_store_i),
        .mode_i             (mode_i),
        .eew_i              (eew_i),
        .vl_i               (vl_i),
        .vm_i               (vm_i),
        .mask_i             (mask_i),
        .base_address_i     (base_address_i),
        .stride_i           (stride_i),
        .write_data_i       (write_data_i),
        .mem_read_data_i    (mem_read_data_i),
        .busy_o             (busy_o),
        .done_o             (done_o),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o),
        .read_data_o        (read_data_o)
    );

    vlsu_checker checker_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .start_i            (start_i),
        .is_store_i         (is_store_i),
        .mode_i             (mode_i),
        .eew_i              (eew_i),
        .vl_i               (vl_i),
        .vm_i               (vm_i),
        .mask_i             (mask_i),
        .base_address_i     (base_address_i),
        .stride_i           (stride_i),
        .write_data_i       (write_data_i),
        .busy_i             (busy_o),
        .done_i             (done_o),
        .mem_address_i      (mem_address_o),
        .mem_read_enable_i  (mem_read_enable_o),
        .mem_write_enable_i (mem_write_enable_o),
        .mem_write_data_i   (mem_write_data_o),
        .read_data_i        (read_data_o),
        .mismatch_count_o   (mismatch_count),
        .error_count_o      (error_count),
        .checked_count_o    (checked_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////
    // Memory model, read data one cycle after the address
    ////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (mem_read_enable_o) begin
            mem_read_data_i <= {mem[{mem_address_o[7:2], 2'd3}], mem[{mem_address_o[7:2], 2'd2}],
                                mem[{mem_address_o[7:2], 2'd1}], mem[{mem_address_o[7:2], 2'd0}]};
        end
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (mem_write_enable_o[b]) begin
                mem[{mem_address_o[7:2], 2'(b)}] <= mem_write_data_o[8*b +: 8];
            end
        end
    end

    // One random command, held until done_o
    task automatic run_command();
        addr_mode_e mode;
        eew_e       eew;
        int         size;
        int         max_vl;
        word_t      base;
        mode   = addr_mode_e'($urandom % 2);
        eew    = eew_e'($urandom % 3);
        size   = 1 << int'(eew);
        max_vl = VLENB / size;
        if (mode == UNIT_STRIDED) begin
            base = word_t'(($urandom % 64) * WORD_BYTES);
        end else begin
            base = word_t'((($urandom % 256) / size) * size);
        end
        is_store_i     <= 1'($urandom % 2);
        mode_i         <= mode;
        eew_i          <= eew;
        vl_i           <= vl_t'($urandom % (max_vl + 1));
        vm_i           <= 1'($urandom % 2);
        mask_i         <= 8'($urandom);
        base_address_i <= base;
        stride_i       <= word_t'(($urandom % 16) * size);
        write_data_i   <= {$urandom, $urandom};
        start_i        <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        @(posedge clk);
        while (!done_o) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk             = 1'b0;
        reset_n         = 1'b0;
        start_i         = 1'b0;
        is_store_i      = 1'b0;
        mode_i          = UNIT_STRIDED;
        eew_i           = EW8;
        vl_i            = '0;
        vm_i            = 1'b0;
        mask_i          = '0;
        base_address_i  = '0;
        stride_i        = '0;
        write_data_i    = '0;
        mem_read_data_i = '0;
        void'($urandom(32'h61d19f68));
        // Fill value differs for every byte address
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'(a * 37 + 11);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        // Idle cycles so the checker sees the quiet state after reset
        repeat (3) @(posedge clk);
        for (int i = 0; i < NUM_CMDS; i++) begin
            run_command();
        end
        repeat (2) @(posedge clk);
        $display("Checked %0d of %0d commands with %0d mismatches and %0d other errors",
                 checked_count, NUM_CMDS, mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0 && checked_count == NUM_CMDS) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== tests/vlsu_checker.sv ====
// Checker with reference memory, load model, done and busy timing checks and error counts

module vlsu_checker
    import vlsu_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             start_i,
    input  logic             is_store_i,
    input  addr_mode_e       mode_i,
    input  eew_e             eew_i,
    input  vl_t              vl_i,
    input  logic             vm_i,
    input  logic [VLENB-1:0] mask_i,
    input  word_t            base_address_i,
    input  word_t            stride_i,
    input  vreg_t            write_data_i,
    input  logic             busy_i,
    input  logic             done_i,
    input  word_t            mem_address_i,
    input  logic             mem_read_enable_i,
    input  byte_en_t         mem_write_enable_i,
    input  word_t            mem_write_data_i,
    input  vreg_t            read_data_i,
    output int               mismatch_count_o,
    output int               error_count_o,
    output int               checked_count_o
);

    // Expected contents, and contents as written by the DUT
    logic [7:0] model_mem [256];
    logic [7:0] seen_mem  [256];
    logic       pending;
    logic       started;
    logic       cmd_store;
    int         cycles;
    int         expect_cycles;
    vreg_t      expect_data;

    initial begin
        mismatch_count_o = 0;
        error_count_o    = 0;
        checked_count_o  = 0;
        pending          = 1'b0;
        started          = 1'b0;
        cmd_store        = 1'b0;
        for (int a = 0; a < 256; a++) begin
            model_mem[a] = 8'(a * 37 + 11);
            seen_mem[a]  = 8'(a * 37 + 11);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Reference model of one command
    ////////////////////////////////////////////////////////////////////////

    task automatic start_model();
        int         size;
        int         per_beat;
        int         beats;
        word_t      addr;
        logic [7:0] a;
        size          = 1 << int'(eew_i);
        per_beat      = (mode_i == UNIT_STRIDED) ? WORD_BYTES / size : 1;
        beats         = (vl_i == 0) ? 1 : (int'(vl_i) + per_beat - 1) / per_beat;
        cmd_store     = is_store_i;
        expect_cycles = beats + (is_store_i ? 1 : 2);
        expect_data   = '0;
        cycles        = 0;
        pending       = 1'b1;
        started       = 1'b1;
        for (int k = 0; k < int'(vl_i); k++) begin
            if (vm_i || mask_i[k]) begin
                if (mode_i == UNIT_STRIDED) begin
                    addr = base_address_i + word_t'(k * size);
                end else begin
                    addr = base_address_i + word_t'(k) * stride_i;
                end
                for (int j = 0; j < size; j++) begin
                    a = 8'(addr + word_t'(j));
                    if (is_store_i) begin
                        model_mem[a] = write_data_i[8*(k*size+j) +: 8];
                    end else begin
                        expect_data[8*(k*size+j) +: 8] = model_mem[a];
                    end
                end
            end
        end
    endtask

    task automatic finish_model();
        if (cycles != expect_cycles) begin
            $display("MISMATCH at %0t: done_o after %0d cycles, expected %0d",
                     $time, cycles, expect_cycles);
            mismatch_count_o++;
        end
        if (busy_i) begin
            $display("Error at %0t: busy_o is still high in the done_o cycle", $time);
            error_count_o++;
        end
        if (cmd_store) begin
            for (int a = 0; a < 256; a++) begin
                if (seen_mem[a] !== model_mem[a]) begin
                    $display("MISMATCH at %0t: memory byte %02h is %02h, expected %02h",
                             $time, a, seen_mem[a], model_mem[a]);
                    mismatch_count_o++;
                end
            end
        end else if (read_data_i !== expect_data) begin
            $display("MISMATCH at %0t: read_data_o is %016h, expected %016h",
                     $time, read_data_i, expect_data);
            mismatch_count_o++;
        end
        pending = 1'b0;
        checked_count_o++;
    endtask

    always @(posedge clk) begin
        if (reset_n) begin
            if (!started && (busy_i || done_i || mem_read_enable_i ||
                             mem_write_enable_i != '0)) begin
                $display("Error at %0t: unit is active after reset before any command", $time);
                error_count_o++;
            end
            // Busy covers every cycle from the first beat up to done
            if (pending && !done_i && !busy_i) begin
                $display("Error at %0t: busy_o is low while a command is in flight", $time);
                error_count_o++;
            end
            if ((mem_read_enable_i && !(pending && !cmd_store)) ||
                (mem_write_enable_i != '0 && !(pending && cmd_store))) begin
                $display("Error at %0t: memory port active outside a matching command", $time);
                error_count_o++;
            end
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (mem_write_enable_i[b]) begin
                    seen_mem[{mem_address_i[7:2], 2'(b)}] = mem_write_data_i[8*b +: 8];
                end
            end
            if (pending) begin
                cycles++;
            end
            if (done_i) begin
                if (pending) begin
                    finish_model();
                end else begin
                    $display("Error at %0t: done_o pulsed with no command in flight", $time);
                    error_count_o++;
                end
            end
            if (start_i && !busy_i) begin
                start_model();
            end
        end
    end

endmodule

// ==== verilog/vector_lsu.sv ====
// Vector load/store unit top level

module vector_lsu
    import vlsu_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             start_i,
    input  logic             is_store_i,
    input  addr_mode_e       mode_i,
    input  eew_e             eew_i,
    input  vl_t              vl_i,
    input  logic             vm_i,
    input  logic [VLENB-1:0] mask_i,
    input  word_t            base_address_i,
    input  word_t            stride_i,
    input  vreg_t            write_data_i,
    input  word_t            mem_read_data_i,
    output logic             busy_o,
    output logic             done_o,
    output word_t            mem_address_o,
    output logic             mem_read_enable_o,
    output byte_en_t         mem_write_enable_o,
    output word_t            mem_write_data_o,
    output vreg_t            read_data_o
);

    logic      beat;
    logic      start_beat;
    logic      last_beat;
    logic      store_done;
    logic      load_done;
    elem_cnt_t elem_index;
    elem_cnt_t elem_beat;
    word_t     address;

    vlsu_control u_control (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .is_store_i   (is_store_i),
        .mode_i       (mode_i),
        .eew_i        (eew_i),
        .vl_i         (vl_i),
        .busy_o       (busy_o),
        .store_done_o (store_done),
        .beat_o       (beat),
        .start_beat_o (start_beat),
        .last_beat_o  (last_beat),
        .elem_index_o (elem_index),
        .elem_beat_o  (elem_beat)
    );

    vlsu_address_gen u_address_gen (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_beat_i   (start_beat),
        .beat_i         (beat),
        .mode_i         (mode_i),
        .base_address_i (base_address_i),
        .stride_i       (stride_i),
        .eew_i          (eew_i),
        .mem_address_o  (address)
    );

    vlsu_store_lanes u_store_lanes (
        .beat_i             (beat),
        .is_store_i         (is_store_i),
        .mode_i             (mode_i),
        .eew_i              (eew_i),
        .vl_i               (vl_i),
        .vm_i               (vm_i),
        .mask_i             (mask_i),
        .write_data_i       (write_data_i),
        .elem_index_i       (elem_index),
        .address_i          (address),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    vlsu_load_assembler u_load_assembler (
        .clk               (clk),
        .reset_n           (reset_n),
        .start_i           (start_i),
        .beat_i            (beat),
        .last_beat_i       (last_beat),
        .is_store_i        (is_store_i),
        .mode_i            (mode_i),
        .eew_i             (eew_i),
        .vl_i              (vl_i),
        .vm_i              (vm_i),
        .mask_i            (mask_i),
        .elem_index_i      (elem_index),
        .elem_beat_i       (elem_beat),
        .address_i         (address),
        .mem_read_data_i   (mem_read_data_i),
        .mem_read_enable_o (mem_read_enable_o),
        .read_data_o       (read_data_o),
        .load_done_o       (load_done)
    );

    assign mem_address_o = address;
    assign done_o        = store_done || load_done;

endmodule

// ==== verilog/vlsu_load_assembler.sv ====
// Load stage-2 registers, read data alignment and result register

module vlsu_load_assembler
    import vlsu_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             start_i,
    input  logic             beat_i,
    input  logic             last_beat_i,
    input  logic             is_store_i,
    input  addr_mode_e       mode_i,
    input  eew_e             eew_i,
    input  vl_t              vl_i,
    input  logic             vm_i,
    input  logic [VLENB-1:0] mask_i,
    input  elem_cnt_t        elem_index_i,
    input  elem_cnt_t        elem_beat_i,
    input  word_t            address_i,
    input  word_t            mem_read_data_i,
    output logic             mem_read_enable_o,
    output vreg_t            read_data_o,
    output logic             load_done_o
);

    logic [1:0] addr_lo_q;
    elem_cnt_t  elem_index_q;
    elem_cnt_t  elem_beat_q;
    logic       load_beat_q;
    logic       last_q;
    logic       done_q;
    logic [1:0] size_mask;
    logic [5:0] byte_base;
    logic [5:0] dst_byte  [WORD_BYTES];
    elem_cnt_t  lane_elem [WORD_BYTES];
    logic       lane_en   [WORD_BYTES];
    vreg_t      result_q;

    assign mem_read_enable_o = beat_i && !is_store_i;

    //////////////////////////////////////////////////////////////////////
    // Stage 1 to stage 2 registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            load_beat_q <= 1'b0;
            last_q      <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            load_beat_q <= beat_i && !is_store_i;
            last_q      <= last_beat_i && !is_store_i;
            done_q      <= last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_i) begin
            addr_lo_q    <= address_i[1:0];
            elem_index_q <= elem_index_i;
            elem_beat_q  <= elem_beat_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2 alignment and merge
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (eew_i)
            EW8:     size_mask = 2'b00;
            EW16:    size_mask = 2'b01;
            default: size_mask = 2'b11;
        endcase
    end

    assign byte_base = {2'b00, elem_index_q} << eew_i;

    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (mode_i == UNIT_STRIDED) begin
                lane_elem[b] = elem_index_q + elem_cnt_t'(b >> eew_i);
                dst_byte[b]  = byte_base + 6'(b);
                lane_en[b]   = (2'(b) >> eew_i) < elem_beat_q;
            end else begin
                // Element sits at the lane given by the address offset
                lane_elem[b] = elem_index_q;
                dst_byte[b]  = byte_base + 6'(b & size_mask);
                lane_en[b]   = (2'(b) >> eew_i) == (addr_lo_q >> eew_i);
            end
            lane_en[b] = lane_en[b] && (lane_elem[b] < vl_i) &&
                         (vm_i || mask_i[lane_elem[b][2:0]]);
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            result_q <= '0;
        end else if (load_beat_q) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (lane_en[b]) begin
                    result_q[8*dst_byte[b] +: 8] <= mem_read_data_i[8*b +: 8];
                end
            end
        end
    end

    assign read_data_o = result_q;
    assign load_done_o = done_q;

endmodule

// ==== verilog/vlsu_store_lanes.sv ====
// Store byte enables and write data lane placement

module vlsu_store_lanes
    import vlsu_pkg::*;
(
    input  logic             beat_i,
    input  logic             is_store_i,
    input  addr_mode_e       mode_i,
    input  eew_e             eew_i,
    input  vl_t              vl_i,
    input  logic             vm_i,
    input  logic [VLENB-1:0] mask_i,
    input  vreg_t            write_data_i,
    input  elem_cnt_t        elem_index_i,
    input  word_t            address_i,
    output byte_en_t         mem_write_enable_o,
    output word_t            mem_write_data_o
);

    logic [1:0] size_mask;
    logic [5:0] byte_base;
    logic [5:0] src_byte  [WORD_BYTES];
    elem_cnt_t  lane_elem [WORD_BYTES];
    logic       lane_sel  [WORD_BYTES];
    byte_en_t   lane_en;
    word_t      wdata;

    always_comb begin
        unique case (eew_i)
            EW8:     size_mask = 2'b00;
            EW16:    size_mask = 2'b01;
            default: size_mask = 2'b11;
        endcase
    end

    // First register byte of the current element
    assign byte_base = {2'b00, elem_index_i} << eew_i;

    //////////////////////////////////////////////////////////////////////
    // Per-lane source byte and enable
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (mode_i == UNIT_STRIDED) begin
                // Consecutive elements fill consecutive lanes
                lane_elem[b] = elem_index_i + elem_cnt_t'(b >> eew_i);
                src_byte[b]  = byte_base + 6'(b);
                lane_sel[b]  = 1'b1;
            end else begin
                // Single element replicated, low address bits pick the lane
                lane_elem[b] = elem_index_i;
                src_byte[b]  = byte_base + 6'(b & size_mask);
                lane_sel[b]  = (2'(b) >> eew_i) == (address_i[1:0] >> eew_i);
            end
            wdata[8*b +: 8] = write_data_i[8*src_byte[b] +: 8];
            lane_en[b]      = lane_sel[b] && (lane_elem[b] < vl_i) &&
                              (vm_i || mask_i[lane_elem[b][2:0]]);
        end
    end

    assign mem_write_enable_o = (is_store_i && beat_i) ? lane_en : '0;
    assign mem_write_data_o   = wdata;

endmodule

// ==== verilog/vlsu_address_gen.sv ====
// Running offset register and per-beat memory address

module vlsu_address_gen
    import vlsu_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       start_beat_i,
    input  logic       beat_i,
    input  addr_mode_e mode_i,
    input  word_t      base_address_i,
    input  word_t      stride_i,
    input  eew_e       eew_i,
    output word_t      mem_address_o
);

    word_t      offset_q;
    word_t      offset_cur;
    word_t      step;
    logic [1:0] size_mask;

    // First beat always starts at the base
    assign offset_cur = start_beat_i ? '0 : offset_q;
    assign step       = (mode_i == UNIT_STRIDED) ? word_t'(WORD_BYTES) : stride_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset_q <= '0;
        end else if (beat_i) begin
            offset_q <= offset_cur + step;
        end
    end

    assign mem_address_o = base_address_i + offset_cur;

    // Byte offset bits that must be zero for the element size
    always_comb begin
        unique case (eew_i)
            EW8:     size_mask = 2'b00;
            EW16:    size_mask = 2'b01;
            default: size_mask = 2'b11;
        endcase
    end

    a_unit_base_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        beat_i && mode_i == UNIT_STRIDED |-> base_address_i[1:0] == 2'b00);

    a_strided_elem_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        beat_i && mode_i == STRIDED |-> (mem_address_o[1:0] & size_mask) == 2'b00);

endmodule

// ==== verilog/vlsu_control.sv ====
// Beat FSM, element counter and end-of-transfer detection

module vlsu_control
    import vlsu_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       start_i,
    input  logic       is_store_i,
    input  addr_mode_e mode_i,
    input  eew_e       eew_i,
    input  vl_t        vl_i,
    output logic       busy_o,
    output logic       store_done_o,
    output logic       beat_o,
    output logic       start_beat_o,
    output logic       last_beat_o,
    output elem_cnt_t  elem_index_o,
    output elem_cnt_t  elem_beat_o
);

    lsu_state_e state_q;
    lsu_state_e state_d;
    elem_cnt_t  elem_index_q;
    elem_cnt_t  elem_beat;
    elem_cnt_t  next_index;
    logic [4:0] covered_next;
    logic       start_ok;
    logic       load_tail_q;
    logic       store_done_q;

    // Elements moved per beat
    always_comb begin
        if (mode_i == STRIDED) begin
            elem_beat = 4'd1;
        end else begin
            unique case (eew_i)
                EW8:     elem_beat = 4'd4;
                EW16:    elem_beat = 4'd2;
                default: elem_beat = 4'd1;
            endcase
        end
    end

    assign next_index   = elem_index_q + elem_beat;
    // Elements done once the following beat completes
    assign covered_next = {1'b0, next_index} + {1'b0, elem_beat};
    assign start_ok     = start_i && !busy_o;

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            VLSU_IDLE: begin
                if (start_ok) begin
                    // vl of zero still takes one empty beat
                    state_d = (elem_beat >= vl_i) ? VLSU_LAST : VLSU_EXEC;
                end
            end
            VLSU_EXEC: begin
                if (covered_next >= {1'b0, vl_i}) begin
                    state_d = VLSU_LAST;
                end
            end
            default: state_d = VLSU_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q      <= VLSU_IDLE;
            elem_index_q <= '0;
            load_tail_q  <= 1'b0;
            store_done_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            elem_index_q <= (state_q == VLSU_IDLE) ? '0 : next_index;
            // Loads still have one word returning after the last beat
            load_tail_q  <= (state_q == VLSU_LAST) && !is_store_i;
            store_done_q <= (state_q == VLSU_LAST) && is_store_i;
        end
    end

    assign beat_o       = (state_q == VLSU_EXEC) || (state_q == VLSU_LAST);
    assign last_beat_o  = (state_q == VLSU_LAST);
    assign start_beat_o = beat_o && (elem_index_q == '0);
    assign elem_index_o = elem_index_q;
    assign elem_beat_o  = elem_beat;
    assign busy_o       = beat_o || load_tail_q;
    assign store_done_o = store_done_q;

    a_index_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        beat_o |-> elem_index_o <= elem_cnt_t'(VLENB));

endmodule

// ==== verilog/vlsu_pkg.sv ====
// Sizes, vector types and enums shared by the vector load/store unit

package vlsu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    // One vector register
    localparam int VLEN       = 64;
    localparam int VLENB      = VLEN / 8;
    // Memory port is one 32-bit word wide
    localparam int WORD_BYTES = 4;

    //////////////////////////////////////////////////////////////////////
    // Vector and word types
    //////////////////////////////////////////////////////////////////////

    typedef logic [VLEN-1:0]       vreg_t;
    typedef logic [31:0]           word_t;
    typedef logic [WORD_BYTES-1:0] byte_en_t;

    // Element index or count, 0 to 8
    typedef logic [3:0]            elem_cnt_t;
    typedef logic [3:0]            vl_t;

    //////////////////////////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////////////////////////

    // Encoding is log2 of the element size in bytes
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } eew_e;

    typedef enum logic {
        UNIT_STRIDED = 1'b0,
        STRIDED      = 1'b1
    } addr_mode_e;

    typedef enum logic [1:0] {
        VLSU_IDLE = 2'd0,
        VLSU_EXEC = 2'd1,
        VLSU_LAST = 2'd2
    } lsu_state_e;

endpackage
